// ==== common/router_pkg.sv ====
package router_pkg;

    // ****************************************
    // sizes
    // ****************************************

    localparam int DWIDTH      = 16;
    localparam int AWIDTH      = 6;
    localparam int NPORTS      = 5;    // port 0 is the gpu and ports 1 to 4 are the spines
    localparam int FIFO_DEPTH  = 8;
    localparam int STALL_LIMIT = 4;    // wait cycles before a blocked grant is dropped

    // the address splits into a group and a spine index
    localparam int GROUP_W = 4;
    localparam int IDX_W   = 2;

    localparam int PORT_W = $clog2(NPORTS);
    localparam int PTR_W  = $clog2(FIFO_DEPTH);
    localparam int CNT_W  = PTR_W + 1;
    localparam int TMR_W  = $clog2(STALL_LIMIT + 1);

    // ****************************************
    // types
    // ****************************************

    typedef logic [DWIDTH-1:0] flit_data_t;
    typedef logic [AWIDTH-1:0] dest_addr_t;    // group on top and spine index below
    typedef logic [PORT_W-1:0] port_id_t;
    typedef logic [NPORTS-1:0] port_mask_t;
    typedef logic [1:0]        route_dir_t;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_ARB  = 2'd1,
        ST_MOVE = 2'd2,
        ST_WAIT = 2'd3
    } arb_state_t;

    // ****************************************
    // constants
    // ****************************************

    localparam logic [GROUP_W-1:0] GROUP_ID = 4'd7;
    localparam port_id_t           GPU_PORT = '0;

    // class of the move shown on routing_direction
    localparam route_dir_t DIR_IDLE  = 2'd0;
    localparam route_dir_t DIR_UP    = 2'd1;    // gpu to spine
    localparam route_dir_t DIR_DOWN  = 2'd2;    // spine to gpu
    localparam route_dir_t DIR_CROSS = 2'd3;    // spine to spine or gpu to gpu

endpackage

// ==== common/flit_if.sv ====
`timescale 1ns/10ps

// one flit stream from a fifo head into the crossbar
interface flit_if;
    import router_pkg::*;

    flit_data_t data;
    dest_addr_t dest;
    logic       valid;
    logic       ready;    // the flit moves when valid and ready are both high

    modport source (
        output data,
        output dest,
        output valid,
        input  ready
    );

    modport sink (
        input  data,
        input  dest,
        input  valid,
        output ready
    );

endinterface

// ==== src/ingress_fifo.sv ====
`timescale 1ns/10ps

module ingress_fifo (
    input  logic                   clk,
    input  logic                   rst_n,
    input  router_pkg::flit_data_t in_data,
    input  router_pkg::dest_addr_t in_dest,
    input  logic                   in_valid,
    output logic                   in_ready,
    flit_if.source                 head,
    output logic                   full,
    output logic                   empty
);
    import router_pkg::*;

    flit_data_t       data_mem [FIFO_DEPTH];
    dest_addr_t       dest_mem [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             push;
    logic             pop;

    assign in_ready = !full;
    assign push     = in_valid && in_ready;
    assign pop      = head.valid && head.ready;    // the crossbar took the head

    // ****************************************
    // storage
    // ****************************************

    always_ff @(posedge clk) begin
        if (push) begin
            data_mem[wr_ptr] <= in_data;
            dest_mem[wr_ptr] <= in_dest;
        end
    end

    // depth is a power of two so the pointers wrap on their own
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;    // no change, or a push and a pop together
            endcase
        end
    end

    // ****************************************
    // head and status
    // ****************************************

    assign full  = (count == CNT_W'(FIFO_DEPTH));
    assign empty = (count == '0);

    assign head.valid = !empty;
    assign head.data  = data_mem[rd_ptr];
    assign head.dest  = dest_mem[rd_ptr];

endmodule

// ==== crossbar/arb_fsm.sv ====
`timescale 1ns/10ps

module arb_fsm (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   arb_enable,
    input  router_pkg::port_mask_t req,
    input  logic                   slot_free,
    input  logic                   expired,
    output router_pkg::port_id_t   grant,
    output logic                   move,
    output logic                   wait_en,
    output logic                   busy
);
    import router_pkg::*;

    arb_state_t state;
    arb_state_t state_nxt;
    port_id_t   last_grant;    // held through MOVE and WAIT
    port_id_t   pick;
    logic       found;
    int         idx;

    // ****************************************
    // round robin search
    // ****************************************

    // start one past the last grant and take the first requester
    always_comb begin
        pick  = last_grant;
        found = 1'b0;
        idx   = 0;
        for (int i = 1; i <= NPORTS; i++) begin
            idx = (int'(last_grant) + i) % NPORTS;
            if (!found && req[idx]) begin
                pick  = port_id_t'(idx);
                found = 1'b1;
            end
        end
    end

    // ****************************************
    // state machine
    // ****************************************

    always_comb begin
        state_nxt = state;
        case (state)
            ST_IDLE: begin
                if (arb_enable) begin
                    state_nxt = ST_ARB;
                end
            end
            ST_ARB: begin
                if (!arb_enable) begin
                    state_nxt = ST_IDLE;
                end else if (found) begin
                    state_nxt = slot_free ? ST_MOVE : ST_WAIT;
                end
            end
            ST_MOVE: begin
                state_nxt = ST_ARB;
            end
            ST_WAIT: begin
                if (slot_free) begin
                    state_nxt = ST_MOVE;
                end else if (expired) begin
                    // the pointer stays on the blocked port so the next search starts after it
                    state_nxt = ST_ARB;
                end
            end
            default: begin
                state_nxt = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            last_grant <= '0;
        end else begin
            state <= state_nxt;
            if (state == ST_ARB && arb_enable && found) begin
                last_grant <= pick;
            end
        end
    end

    // the crossbar sees the candidate in ARB so it can answer with slot_free
    assign grant   = (state == ST_ARB) ? pick : last_grant;
    assign move    = (state == ST_MOVE);
    assign wait_en = (state == ST_WAIT);
    assign busy    = (state == ST_MOVE) || (state == ST_WAIT);

endmodule

// ==== crossbar/grant_timer.sv ====
`timescale 1ns/10ps

module grant_timer (
    input  logic clk,
    input  logic rst_n,
    input  logic wait_en,
    output logic expired
);
    import router_pkg::*;

    logic [TMR_W-1:0] count;

    // counts wait cycles and holds at the limit
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!wait_en) begin
            count <= '0;
        end else if (!expired) begin
            count <= count + 1'b1;
        end
    end

    assign expired = (count == TMR_W'(STALL_LIMIT));

endmodule

// ==== crossbar/crossbar_switch.sv ====
`timescale 1ns/10ps

module crossbar_switch (
    input  logic                   clk,
    input  logic                   rst_n,
    flit_if.sink                   heads [router_pkg::NPORTS],
    input  router_pkg::port_id_t   grant,
    input  logic                   move,
    output router_pkg::port_mask_t req,
    output logic                   slot_free,
    output router_pkg::route_dir_t direction,
    output router_pkg::flit_data_t out_data [router_pkg::NPORTS],
    output router_pkg::port_mask_t out_valid,
    input  router_pkg::port_mask_t out_ready
);
    import router_pkg::*;

    flit_data_t head_data [NPORTS];
    dest_addr_t head_dest [NPORTS];
    flit_data_t sel_data;
    dest_addr_t sel_dest;
    port_id_t   target;
    port_mask_t load;

    // flatten the heads so the granted one can be picked by index
    for (genvar p = 0; p < NPORTS; p++) begin : g_head
        assign head_data[p]   = heads[p].data;
        assign head_dest[p]   = heads[p].dest;
        assign req[p]         = heads[p].valid;
        assign heads[p].ready = move && (grant == port_id_t'(p));
    end

    assign sel_data = head_data[grant];
    assign sel_dest = head_dest[grant];

    // ****************************************
    // route decode
    // ****************************************

    // own group goes down to the gpu and anything else up to the indexed spine
    always_comb begin
        if (sel_dest[AWIDTH-1 -: GROUP_W] == GROUP_ID) begin
            target = GPU_PORT;
        end else begin
            target = port_id_t'(sel_dest[IDX_W-1:0]) + 1'b1;
        end
    end

    assign slot_free = !out_valid[target];
    assign load      = move ? (port_mask_t'(1) << target) : '0;

    always_comb begin
        direction = DIR_IDLE;
        if (move) begin
            if (grant == GPU_PORT && target != GPU_PORT) begin
                direction = DIR_UP;
            end else if (grant != GPU_PORT && target == GPU_PORT) begin
                direction = DIR_DOWN;
            end else begin
                direction = DIR_CROSS;
            end
        end
    end

    // ****************************************
    // output slots
    // ****************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            out_valid <= '0;
        end else begin
            out_valid <= (out_valid & ~out_ready) | load;    // a slot is only loaded when empty
        end
    end

    always_ff @(posedge clk) begin
        for (int p = 0; p < NPORTS; p++) begin
            if (load[p]) begin
                out_data[p] <= sel_data;
            end
        end
    end

endmodule

// ==== src/router_top.sv ====
`timescale 1ns/10ps

module router_top (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   arb_enable,

    input  router_pkg::flit_data_t gpu_in_data,
    input  logic                   gpu_in_valid,
    input  router_pkg::dest_addr_t gpu_in_dest,
    output logic                   gpu_in_ready,
    output router_pkg::flit_data_t gpu_out_data,
    output logic                   gpu_out_valid,
    input  logic                   gpu_out_ready,

    input  router_pkg::flit_data_t spine1_in_data,
    input  logic                   spine1_in_valid,
    input  router_pkg::dest_addr_t spine1_in_dest,
    output logic                   spine1_in_ready,
    output router_pkg::flit_data_t spine1_out_data,
    output logic                   spine1_out_valid,
    input  logic                   spine1_out_ready,

    input  router_pkg::flit_data_t spine2_in_data,
    input  logic                   spine2_in_valid,
    input  router_pkg::dest_addr_t spine2_in_dest,
    output logic                   spine2_in_ready,
    output router_pkg::flit_data_t spine2_out_data,
    output logic                   spine2_out_valid,
    input  logic                   spine2_out_ready,

    input  router_pkg::flit_data_t spine3_in_data,
    input  logic                   spine3_in_valid,
    input  router_pkg::dest_addr_t spine3_in_dest,
    output logic                   spine3_in_ready,
    output router_pkg::flit_data_t spine3_out_data,
    output logic                   spine3_out_valid,
    input  logic                   spine3_out_ready,

    input  router_pkg::flit_data_t spine4_in_data,
    input  logic                   spine4_in_valid,
    input  router_pkg::dest_addr_t spine4_in_dest,
    output logic                   spine4_in_ready,
    output router_pkg::flit_data_t spine4_out_data,
    output logic                   spine4_out_valid,
    input  logic                   spine4_out_ready,

    output router_pkg::port_mask_t fifo_full,
    output router_pkg::port_mask_t fifo_empty,
    output logic                   crossbar_busy,
    output router_pkg::port_id_t   current_grant,
    output router_pkg::route_dir_t routing_direction
);
    import router_pkg::*;

    flit_data_t in_data  [NPORTS];
    dest_addr_t in_dest  [NPORTS];
    port_mask_t in_valid;
    port_mask_t in_ready;
    flit_data_t out_data [NPORTS];
    port_mask_t out_valid;
    port_mask_t out_ready;
    port_mask_t req;
    logic       slot_free;
    logic       move;
    logic       wait_en;
    logic       expired;

    flit_if head_if [NPORTS] ();

    // index 0 is the gpu and 1 to 4 follow the spine numbers
    assign in_data   = '{gpu_in_data, spine1_in_data, spine2_in_data, spine3_in_data,
                         spine4_in_data};
    assign in_dest   = '{gpu_in_dest, spine1_in_dest, spine2_in_dest, spine3_in_dest,
                         spine4_in_dest};
    assign in_valid  = {spine4_in_valid, spine3_in_valid, spine2_in_valid, spine1_in_valid,
                        gpu_in_valid};
    assign out_ready = {spine4_out_ready, spine3_out_ready, spine2_out_ready,
                        spine1_out_ready, gpu_out_ready};

    assign {spine4_in_ready, spine3_in_ready, spine2_in_ready, spine1_in_ready,
            gpu_in_ready} = in_ready;
    assign {spine4_out_valid, spine3_out_valid, spine2_out_valid, spine1_out_valid,
            gpu_out_valid} = out_valid;

    assign gpu_out_data    = out_data[0];
    assign spine1_out_data = out_data[1];
    assign spine2_out_data = out_data[2];
    assign spine3_out_data = out_data[3];
    assign spine4_out_data = out_data[4];

    for (genvar p = 0; p < NPORTS; p++) begin : g_port
        ingress_fifo u_fifo (
            .clk      (clk),
            .rst_n    (rst_n),
            .in_data  (in_data[p]),
            .in_dest  (in_dest[p]),
            .in_valid (in_valid[p]),
            .in_ready (in_ready[p]),
            .head     (head_if[p]),
            .full     (fifo_full[p]),
            .empty    (fifo_empty[p])
        );
    end

    arb_fsm u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .arb_enable (arb_enable),
        .req        (req),
        .slot_free  (slot_free),
        .expired    (expired),
        .grant      (current_grant),
        .move       (move),
        .wait_en    (wait_en),
        .busy       (crossbar_busy)
    );

    grant_timer u_timer (
        .clk     (clk),
        .rst_n   (rst_n),
        .wait_en (wait_en),
        .expired (expired)
    );

    crossbar_switch u_xbar (
        .clk       (clk),
        .rst_n     (rst_n),
        .heads     (head_if),
        .grant     (current_grant),
        .move      (move),
        .req       (req),
        .slot_free (slot_free),
        .direction (routing_direction),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

endmodule

// ==== testbench/router_asserts.sv ====
`timescale 1ns/10ps

module router_asserts (
    input logic                   clk,
    input logic                   rst_n,
    input router_pkg::arb_state_t state,
    input router_pkg::port_mask_t req,
    input router_pkg::port_id_t   grant,
    input logic                   move,
    input logic                   expired,
    input logic                   busy
);
    import router_pkg::*;

    int fail_count = 0;

    // a move only takes a flit from a port that still holds one
    a_move_req: assert property (@(posedge clk) disable iff (!rst_n)
        move |-> req[grant])
        else begin
            fail_count++;
            $error("move on port %0d without a request", grant);
        end

    a_wait_exit: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_WAIT && expired) |=> (state != ST_WAIT))
        else begin
            fail_count++;
            $error("arbiter stayed in wait after the timer expired");
        end

    a_idle_busy: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_IDLE) |-> !busy)
        else begin
            fail_count++;
            $error("busy is high in idle");
        end

    // the grant picked in arb is held until the move or the timeout
    a_grant_hold: assert property (@(posedge clk) disable iff (!rst_n)
        (state == ST_MOVE || state == ST_WAIT) |-> $stable(grant))
        else begin
            fail_count++;
            $error("grant changed after arbitration");
        end

endmodule

bind arb_fsm router_asserts u_asserts (
    .clk     (clk),
    .rst_n   (rst_n),
    .state   (state),
    .req     (req),
    .grant   (grant),
    .move    (move),
    .expired (expired),
    .busy    (busy)
);

// ==== testbench/router_tb.sv ====
`timescale 1ns/10ps

module router_tb;
    import router_pkg::*;

    localparam int       N_FLITS    = 400;
    localparam int       MAX_CYCLES = N_FLITS * 40 + 2000;
    localparam int       BP_CYCLES  = 300;
    localparam int       OFF_CYCLES = 60;
    localparam port_id_t BLOCKED    = 3'd2;    // spine2 output held in phase 1

    logic       clk;
    logic       rst_n;
    logic       arb_enable;
    flit_data_t in_data [NPORTS];
    dest_addr_t in_dest [NPORTS];
    port_mask_t in_valid;
    port_mask_t in_ready;
    flit_data_t out_data [NPORTS];
    port_mask_t out_valid;
    port_mask_t out_ready;
    port_mask_t fifo_full;
    port_mask_t fifo_empty;
    logic       crossbar_busy;
    port_id_t   current_grant;
    route_dir_t routing_direction;

    // expected flits, one queue per source and target at src * NPORTS + target
    flit_data_t exp_q [NPORTS*NPORTS][$];
    int         pair_seen [NPORTS*NPORTS];
    int         fifo_level [NPORTS];
    int         seq [NPORTS];
    port_mask_t took       = '0;
    port_mask_t last_valid = '0;
    port_id_t   last_grant = '0;
    route_dir_t last_dir   = DIR_IDLE;
    logic       last_busy  = 1'b0;
    int         accepted   = 0;
    int         delivered  = 0;
    int         other_seen = 0;
    int         cycles     = 0;
    int         phase      = 0;    // 0 random traffic, 1 spine2 blocked
    logic       arb_off    = 1'b0;
    logic       saw_full   = 1'b0;

    router_top i_router_top (
        .clk               (clk),
        .rst_n             (rst_n),
        .arb_enable        (arb_enable),
        .gpu_in_data       (in_data[0]),
        .gpu_in_valid      (in_valid[0]),
        .gpu_in_dest       (in_dest[0]),
        .gpu_in_ready      (in_ready[0]),
        .gpu_out_data      (out_data[0]),
        .gpu_out_valid     (out_valid[0]),
        .gpu_out_ready     (out_ready[0]),
        .spine1_in_data    (in_data[1]),
        .spine1_in_valid   (in_valid[1]),
        .spine1_in_dest    (in_dest[1]),
        .spine1_in_ready   (in_ready[1]),
        .spine1_out_data   (out_data[1]),
        .spine1_out_valid  (out_valid[1]),
        .spine1_out_ready  (out_ready[1]),
        .spine2_in_data    (in_data[2]),
        .spine2_in_valid   (in_valid[2]),
        .spine2_in_dest    (in_dest[2]),
        .spine2_in_ready   (in_ready[2]),
        .spine2_out_data   (out_data[2]),
        .spine2_out_valid  (out_valid[2]),
        .spine2_out_ready  (out_ready[2]),
        .spine3_in_data    (in_data[3]),
        .spine3_in_valid   (in_valid[3]),
        .spine3_in_dest    (in_dest[3]),
        .spine3_in_ready   (in_ready[3]),
        .spine3_out_data   (out_data[3]),
        .spine3_out_valid  (out_valid[3]),
        .spine3_out_ready  (out_ready[3]),
        .spine4_in_data    (in_data[4]),
        .spine4_in_valid   (in_valid[4]),
        .spine4_in_dest    (in_dest[4]),
        .spine4_in_ready   (in_ready[4]),
        .spine4_out_data   (out_data[4]),
        .spine4_out_valid  (out_valid[4]),
        .spine4_out_ready  (out_ready[4]),
        .fifo_full         (fifo_full),
        .fifo_empty        (fifo_empty),
        .crossbar_busy     (crossbar_busy),
        .current_grant     (current_grant),
        .routing_direction (routing_direction)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > MAX_CYCLES) begin
            fail_stop($sformatf("timeout, the run did not finish within %0d cycles", MAX_CYCLES));
        end
    end

    // ****************************************
    // checks
    // ****************************************

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_data(input string name, input flit_data_t exp, input flit_data_t got);
        if (got !== exp) begin
            fail_stop($sformatf("ERROR at %0t: %s expected %h got %h", $time, name, exp, got));
        end
    endtask

    task automatic check_port(input string name, input port_id_t exp, input port_id_t got);
        if (got !== exp) begin
            fail_stop($sformatf("ERROR at %0t: %s expected %0d got %0d", $time, name, exp, got));
        end
    endtask

    task automatic check_mask(input string name, input port_mask_t exp, input port_mask_t got);
        if (got !== exp) begin
            fail_stop($sformatf("ERROR at %0t: %s expected %b got %b", $time, name, exp, got));
        end
    endtask

    task automatic check_dir(input string name, input route_dir_t exp, input route_dir_t got);
        if (got !== exp) begin
            fail_stop($sformatf("ERROR at %0t: %s expected %0d got %0d", $time, name, exp, got));
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic got);
        if (got !== exp) begin
            fail_stop($sformatf("ERROR at %0t: %s expected %b got %b", $time, name, exp, got));
        end
    endtask

    // ****************************************
    // reference model
    // ****************************************

    // own group goes to the gpu, every other group to the spine named by the index
    function automatic port_id_t target_of(input dest_addr_t d);
        int group;
        int spine;
        group = int'(d) / 4;
        spine = int'(d) % 4 + 1;
        if (group == int'(GROUP_ID)) begin
            return '0;
        end
        return port_id_t'(spine);
    endfunction

    // moves between the gpu and a spine go up or down, the rest count as cross
    function automatic route_dir_t dir_of(input int src, input int dst);
        if ((src == 0) == (dst == 0)) begin
            return DIR_CROSS;
        end
        return (src == 0) ? DIR_UP : DIR_DOWN;
    endfunction

    function automatic dest_addr_t pick_dest(input int src);
        dest_addr_t d;
        if (phase == 1 && src == 0) begin
            return {4'd3, 2'd1};    // gpu traffic all heads for the blocked spine2
        end
        do begin
            d = dest_addr_t'($urandom);
            if ($urandom % 4 == 0) begin
                d[AWIDTH-1 -: 4] = GROUP_ID;
            end
        end while (phase == 1 && target_of(d) == BLOCKED);
        return d;
    endfunction

    // everything is judged on the settled values half a cycle after the drive
    always @(negedge clk) begin
        port_id_t   src;
        port_mask_t full_exp;
        port_mask_t empty_exp;
        flit_data_t want;
        int         q;
        int         loads;
        if (rst_n) begin
            if (i_router_top.u_arb.u_asserts.fail_count != 0) begin
                fail_stop("an assertion on the arbiter failed");
            end
            if (arb_off) begin
                check_flag("crossbar_busy", 1'b0, crossbar_busy);
                check_dir("routing_direction", DIR_IDLE, routing_direction);
            end
            loads = 0;
            for (int t = 0; t < NPORTS; t++) begin
                src = out_data[t][DWIDTH-1 -: 3];
                if (out_valid[t] && !last_valid[t]) begin    // slot loaded at the last edge
                    if (arb_off) begin
                        fail_stop($sformatf("port %0d got a flit while arbitration was off", t));
                    end
                    if (int'(src) >= NPORTS) begin
                        fail_stop($sformatf("port %0d shows an unknown source %0d", t, src));
                    end
                    // the move cycle before the load showed the grant and its class
                    check_port("current_grant", src, last_grant);
                    check_dir("routing_direction", dir_of(int'(src), t), last_dir);
                    check_flag("crossbar_busy", 1'b1, last_busy);
                    loads++;
                    fifo_level[src]--;
                end
                if (out_valid[t] && out_ready[t]) begin
                    q = int'(src) * NPORTS + t;
                    if (exp_q[q].size() == 0) begin
                        fail_stop($sformatf("flit %h reached port %0d but none was expected there",
                                            out_data[t], t));
                    end
                    want = exp_q[q].pop_front();
                    check_data($sformatf("out_data[%0d]", t), want, out_data[t]);
                    pair_seen[q]++;
                    delivered++;
                    if (phase == 1 && saw_full && t != int'(BLOCKED)) begin
                        other_seen++;
                    end
                end
            end
            if (loads == 0) begin
                check_dir("routing_direction", DIR_IDLE, last_dir);
            end
            for (int p = 0; p < NPORTS; p++) begin
                full_exp[p]  = (fifo_level[p] == FIFO_DEPTH);
                empty_exp[p] = (fifo_level[p] == 0);
            end
            check_mask("fifo_full", full_exp, fifo_full);
            check_mask("fifo_empty", empty_exp, fifo_empty);
            check_mask("in_ready", ~full_exp, in_ready);
            if (phase == 1 && !in_ready[0]) begin
                saw_full = 1'b1;
            end
            for (int p = 0; p < NPORTS; p++) begin
                took[p] = in_valid[p] && in_ready[p];
                if (took[p]) begin
                    exp_q[p * NPORTS + int'(target_of(in_dest[p]))].push_back(in_data[p]);
                    fifo_level[p]++;
                    seq[p]++;
                    accepted++;
                end
            end
            last_valid = out_valid;
            last_grant = current_grant;
            last_dir   = routing_direction;
            last_busy  = crossbar_busy;
        end
    end

    // ****************************************
    // stimulus
    // ****************************************

    // a flit stays on the port until it is taken
    task automatic drive_inputs(input bit offer);
        for (int p = 0; p < NPORTS; p++) begin
            if (took[p] || !in_valid[p]) begin
                if (offer && ($urandom % 4 != 0)) begin
                    in_valid[p] = 1'b1;
                    in_data[p]  = {port_id_t'(p), seq[p][12:0]};
                    in_dest[p]  = pick_dest(p);
                end else begin
                    in_valid[p] = 1'b0;
                end
            end
        end
    endtask

    task automatic step(input bit offer);
        @(posedge clk);
        #1;
        out_ready = port_mask_t'($urandom | $urandom);
        if (phase == 1) begin
            out_ready[BLOCKED] = 1'b0;
        end
        drive_inputs(offer);
    endtask

    task automatic drain();
        while (in_valid != '0 || delivered != accepted) begin
            step(1'b0);
        end
    endtask

    initial begin
        void'($urandom(32'h8b35));
        rst_n      = 1'b0;
        arb_enable = 1'b1;
        in_valid   = '0;
        out_ready  = '0;
        for (int p = 0; p < NPORTS; p++) begin
            in_data[p]    = '0;
            in_dest[p]    = '0;
            fifo_level[p] = 0;
            seq[p]        = 0;
        end
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;
        check_mask("out_valid", '0, out_valid);
        check_mask("fifo_full", '0, fifo_full);
        check_mask("fifo_empty", '1, fifo_empty);
        check_mask("in_ready", '1, in_ready);
        check_flag("crossbar_busy", 1'b0, crossbar_busy);
        check_port("current_grant", '0, current_grant);
        check_dir("routing_direction", DIR_IDLE, routing_direction);

        while (accepted < N_FLITS) begin
            step(1'b1);
        end
        drain();

        // spine2 held off, the gpu queue fills while the spines keep moving
        phase = 1;
        repeat (BP_CYCLES) step(1'b1);
        if (!saw_full) begin
            fail_stop("the gpu ingress FIFO never filled behind the blocked spine2 output");
        end
        if (other_seen < 10) begin
            fail_stop("flits to unblocked ports stopped while spine2 was held");
        end

        phase = 0;
        step(1'b1);
        arb_enable = 1'b0;
        repeat (10) step(1'b1);    // let a grant in flight finish
        arb_off = 1'b1;
        repeat (OFF_CYCLES) step(1'b1);
        arb_off    = 1'b0;
        arb_enable = 1'b1;
        drain();
        repeat (4) step(1'b0);

        for (int q = 0; q < NPORTS * NPORTS; q++) begin
            if (pair_seen[q] == 0) begin
                fail_stop($sformatf("no flit went from port %0d to port %0d", q / NPORTS,
                                    q % NPORTS));
            end
        end
        check_mask("fifo_empty", '1, fifo_empty);
        check_mask("out_valid", '0, out_valid);
        if (delivered == accepted) begin
            $display("Test completed successfully");
            $finish;
        end else begin
            fail_stop($sformatf("%0d flits accepted but %0d delivered", accepted, delivered));
        end
    end

endmodule

// ==== files.f ====
common/router_pkg.sv
common/flit_if.sv
src/ingress_fifo.sv
crossbar/arb_fsm.sv
crossbar/grant_timer.sv
crossbar/crossbar_switch.sv
src/router_top.sv
testbench/router_asserts.sv
testbench/router_tb.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = router_tb
FILELIST  = files.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = Test completed successfully
SOURCES   = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) +verilator+error+limit+100 | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
